// ==== Bender.yml ====
package:
  name: srt_frac_div

sources:
  - include_dirs:
      - hw
    files:
      - hw/srt_div_pkg.sv
      - hw/srt_rem_if.sv
      - hw/div_ctrl.sv
      - hw/div_prescale.sv
      - hw/div_r4_stage.sv
      - hw/div_srt_core.sv
      - hw/div_post.sv
      - hw/srt_frac_div.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/tb_srt_frac_div.sv

// ==== compile.f ====
+incdir+hw
hw/srt_div_pkg.sv
hw/srt_rem_if.sv
hw/div_ctrl.sv
hw/div_prescale.sv
hw/div_r4_stage.sv
hw/div_srt_core.sv
hw/div_post.sv
hw/srt_frac_div.sv
sim/tb_srt_frac_div.sv

// ==== hw/div_ctrl.sv ====
`timescale 1ns/1ps
`include "srt_div_defs.svh"

module div_ctrl
	import srt_div_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  logic    start_valid_i,
	input  logic    flush_i,
	input  logic    finish_ready_i,
	input  fp_fmt_e fp_format_i,
	output logic    start_ready_o,
	output logic    finish_valid_o,
	output logic    load_o,
	output logic    iter_o,
	output logic    capture_o
);

	div_state_e             state_q;
	div_state_e             state_d;
	logic [`ITER_CNT_W-1:0] cnt_q;
	logic [`ITER_CNT_W-1:0] cnt_init;

	// ==============================
	// iteration count per format
	// ==============================
	// loaded as N-1 so that zero marks the last iteration cycle
	always_comb begin
		case (fp_format_i)
			FMT_FP16: cnt_init = `ITER_CNT_W'(`ITER_FP16 - 1);
			FMT_FP32: cnt_init = `ITER_CNT_W'(`ITER_FP32 - 1);
			default:  cnt_init = `ITER_CNT_W'(`ITER_FP64 - 1);
		endcase
	end

	// format is sampled every idle cycle, so the accept edge keeps the right count
	always_ff @(posedge clk) begin
		if (state_q == DIV_IDLE)
			cnt_q <= cnt_init;
		else if (state_q == DIV_ITER)
			cnt_q <= cnt_q - `ITER_CNT_W'(1);
	end

	// ==============================
	// state machine
	// ==============================
	always_comb begin
		state_d = state_q;
		case (state_q)
			DIV_IDLE: if (start_valid_i) state_d = DIV_ITER;
			DIV_ITER: if (cnt_q == '0) state_d = DIV_POST;
			DIV_POST: state_d = DIV_DONE;
			DIV_DONE: if (finish_ready_i) state_d = DIV_IDLE;
			default:  state_d = DIV_IDLE;
		endcase
		// flush wins over any handshake
		if (flush_i)
			state_d = DIV_IDLE;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state_q <= DIV_IDLE;
		else
			state_q <= state_d;
	end

	// decoded state levels
	assign start_ready_o  = (state_q == DIV_IDLE);
	assign load_o         = (state_q == DIV_IDLE);
	assign iter_o         = (state_q == DIV_ITER);
	assign capture_o      = (state_q == DIV_POST);
	assign finish_valid_o = (state_q == DIV_DONE);

endmodule

// ==== hw/div_post.sv ====
`timescale 1ns/1ps
`include "srt_div_defs.svh"

module div_post (
	input  logic              clk,
	input  logic              capture_i,
	srt_rem_if.post           rem,
	output logic [`QUO_W-1:0] quo_o
);

	logic [`REM_W-1:0] div_ext;
	logic [`REM_W-1:0] rem_raw;
	logic [`REM_W-1:0] rem_fix;
	logic [`REM_W-1:0] rem_dbl;
	logic              rem_neg;
	logic              half_bit;
	logic [`QUO_W-1:0] quo_nr;
	logic [`QUO_W-1:0] quo_fix;

	assign div_ext = {1'b0, rem.divisor, {(`REM_W - `SCALED_W - 1){1'b0}}};

	// ==============================
	// sign correction
	// ==============================
	// full carry-propagate add, only its sign matters for the quotient
	assign rem_raw = rem.rem_sum + rem.rem_carry;
	assign rem_neg = rem_raw[`REM_W-1];

	// redundant to binary, wraps cleanly since the true value fits
	assign quo_nr  = rem.quo_pos - rem.quo_neg;
	assign quo_fix = rem_neg ? quo_nr - `QUO_W'(1) : quo_nr;

	// remainder that goes with the corrected quotient, in [0, D)
	assign rem_fix = rem_neg ? rem_raw + div_ext : rem_raw;

	// one more radix-2 step gives the low quotient bit
	assign rem_dbl  = {rem_fix[`REM_W-2:0], 1'b0} - div_ext;
	assign half_bit = ~rem_dbl[`REM_W-1];

	// result stays put through the finish handshake
	always_ff @(posedge clk) begin
		if (capture_i)
			quo_o <= {quo_fix[`QUO_W-2:0], half_bit};
	end

endmodule

// ==== hw/div_prescale.sv ====
`timescale 1ns/1ps
`include "srt_div_defs.svh"

module div_prescale
	import srt_div_pkg::*;
(
	input  fp_fmt_e               fp_format_i,
	input  logic [`FRAC_W-1:0]    a_frac_i,
	input  logic [`FRAC_W-1:0]    b_frac_i,
	output logic [`REM_W-1:0]     rem_init_o,
	output logic [`SCALED_W-1:0]  divisor_o
);

	logic [`FRAC_W-1:0]   a_al;
	logic [`FRAC_W-1:0]   b_al;
	logic [2:0]           scale_sel;
	logic [`SCALE_W-1:0]  scale;
	logic [`SCALED_W-1:0] x_scaled;
	logic [`SCALED_W-1:0] d_scaled;
	logic                 x_lt_d;

	// ==============================
	// format alignment
	// ==============================
	// significands arrive right aligned, move the leading one to the msb
	always_comb begin
		case (fp_format_i)
			FMT_FP16: begin
				a_al = {a_frac_i[`FP16_FRAC_W-1:0], {(`FRAC_W - `FP16_FRAC_W){1'b0}}};
				b_al = {b_frac_i[`FP16_FRAC_W-1:0], {(`FRAC_W - `FP16_FRAC_W){1'b0}}};
			end
			FMT_FP32: begin
				a_al = {a_frac_i[`FP32_FRAC_W-1:0], {(`FRAC_W - `FP32_FRAC_W){1'b0}}};
				b_al = {b_frac_i[`FP32_FRAC_W-1:0], {(`FRAC_W - `FP32_FRAC_W){1'b0}}};
			end
			default: begin
				a_al = a_frac_i[`FP64_FRAC_W-1:0];
				b_al = b_frac_i[`FP64_FRAC_W-1:0];
			end
		endcase
	end

	// ==============================
	// scaling factor
	// ==============================
	// three divisor bits below the leading one
	assign scale_sel = b_al[`FRAC_W-2 -: 3];

	// factor in sixteenths, brings the divisor into [63/64, 9/8)
	always_comb begin
		case (scale_sel)
			3'd0:    scale = `SCALE_W'(16);
			3'd1:    scale = `SCALE_W'(14);
			3'd2:    scale = `SCALE_W'(13);
			3'd3:    scale = `SCALE_W'(12);
			3'd4:    scale = `SCALE_W'(11);
			3'd5:    scale = `SCALE_W'(10);
			default: scale = `SCALE_W'(9);
		endcase
	end

	// both operands get the same factor, the ratio is unchanged
	assign x_scaled = a_al * scale;
	assign d_scaled = b_al * scale;
	assign x_lt_d   = (x_scaled < d_scaled);

	// ==============================
	// initial remainder
	// ==============================
	// w0 lands in [D/4, D/2) either way, inside the 2D/3 bound
	assign rem_init_o = x_lt_d ?
		{{(`REM_W - `SCALED_W - 1){1'b0}}, x_scaled, 1'b0} :
		{{(`REM_W - `SCALED_W){1'b0}}, x_scaled};

	assign divisor_o = d_scaled;

endmodule

// ==== hw/div_r4_stage.sv ====
`timescale 1ns/1ps
`include "srt_div_defs.svh"

module div_r4_stage
	import srt_div_pkg::*;
(
	input  logic [`REM_W-1:0]    sum_i,
	input  logic [`REM_W-1:0]    carry_i,
	input  logic [`SCALED_W-1:0] divisor_i,
	input  logic [`QUO_W-1:0]    quo_pos_i,
	input  logic [`QUO_W-1:0]    quo_neg_i,
	output logic [`REM_W-1:0]    sum_o,
	output logic [`REM_W-1:0]    carry_o,
	output logic [`QUO_W-1:0]    quo_pos_o,
	output logic [`QUO_W-1:0]    quo_neg_o
);

	// selection thresholds on 4w in eighths
	// low side is one lower since the truncated estimate only rounds down
	localparam logic signed [`EST_W-1:0] TH_POS2 = 12;
	localparam logic signed [`EST_W-1:0] TH_POS1 = 4;
	localparam logic signed [`EST_W-1:0] TH_ZERO = -4;
	localparam logic signed [`EST_W-1:0] TH_NEG1 = -13;

	logic signed [`EST_W-1:0] est;
	quo_dig_e                 dig;
	logic [`REM_W-1:0]        div_ext;
	logic [`REM_W-1:0]        sum_sh;
	logic [`REM_W-1:0]        carry_sh;
	logic [`REM_W-1:0]        addend;
	logic [`REM_W-1:0]        maj;
	logic                     cin;

	// ==============================
	// digit selection
	// ==============================
	// bits under the two guard bits, once shifted they weigh -4 down to 1/8
	assign est = sum_i[`REM_W-3 -: `EST_W] + carry_i[`REM_W-3 -: `EST_W];

	always_comb begin
		if (est >= TH_POS2)
			dig = DIG_POS2;
		else if (est >= TH_POS1)
			dig = DIG_POS1;
		else if (est >= TH_ZERO)
			dig = DIG_ZERO;
		else if (est >= TH_NEG1)
			dig = DIG_NEG1;
		else
			dig = DIG_NEG2;
	end

	// ==============================
	// remainder update
	// ==============================
	// divisor unit aligned with the remainder unit, bit REM_W-3
	assign div_ext = {1'b0, divisor_i, {(`REM_W - `SCALED_W - 1){1'b0}}};

	// subtract q*D, positive digits go in as one's complement plus cin
	always_comb begin
		addend = '0;
		cin    = 1'b0;
		case (dig)
			DIG_POS2: begin
				addend = ~{div_ext[`REM_W-2:0], 1'b0};
				cin    = 1'b1;
			end
			DIG_POS1: begin
				addend = ~div_ext;
				cin    = 1'b1;
			end
			DIG_NEG1: addend = div_ext;
			DIG_NEG2: addend = {div_ext[`REM_W-2:0], 1'b0};
			default:  addend = '0;
		endcase
	end

	// 4w, bits shifted out on top are only sign copies
	assign sum_sh   = {sum_i[`REM_W-3:0], 2'b00};
	assign carry_sh = {carry_i[`REM_W-3:0], 2'b00};

	// 3:2 compressor, the free carry lsb takes the +1
	assign maj     = (sum_sh & carry_sh) | (sum_sh & addend) | (carry_sh & addend);
	assign sum_o   = sum_sh ^ carry_sh ^ addend;
	assign carry_o = {maj[`REM_W-2:0], cin};

	// append two bits to the redundant quotient
	assign quo_pos_o = {quo_pos_i[`QUO_W-3:0], dig == DIG_POS2, dig == DIG_POS1};
	assign quo_neg_o = {quo_neg_i[`QUO_W-3:0], dig == DIG_NEG2, dig == DIG_NEG1};

endmodule

// ==== hw/div_srt_core.sv ====
`timescale 1ns/1ps
`include "srt_div_defs.svh"

module div_srt_core (
	input  logic                 clk,
	input  logic                 load_i,
	input  logic                 iter_i,
	input  logic [`REM_W-1:0]    rem_init_i,
	input  logic [`SCALED_W-1:0] divisor_i,
	srt_rem_if.core              rem
);

	logic [`REM_W-1:0]    sum_q;
	logic [`REM_W-1:0]    carry_q;
	logic [`SCALED_W-1:0] divisor_q;
	logic [`QUO_W-1:0]    pos_q;
	logic [`QUO_W-1:0]    neg_q;

	// stage chain, entry 0 is the register side
	logic [`REM_W-1:0] sum_c   [0:`STAGES_PER_CYCLE];
	logic [`REM_W-1:0] carry_c [0:`STAGES_PER_CYCLE];
	logic [`QUO_W-1:0] pos_c   [0:`STAGES_PER_CYCLE];
	logic [`QUO_W-1:0] neg_c   [0:`STAGES_PER_CYCLE];

	assign sum_c[0]   = sum_q;
	assign carry_c[0] = carry_q;
	assign pos_c[0]   = pos_q;
	assign neg_c[0]   = neg_q;

	// ==============================
	// three radix-4 steps per cycle
	// ==============================
	div_r4_stage u_stage0 (
		.sum_i(sum_c[0]), .carry_i(carry_c[0]), .divisor_i(divisor_q),
		.quo_pos_i(pos_c[0]), .quo_neg_i(neg_c[0]),
		.sum_o(sum_c[1]), .carry_o(carry_c[1]), .quo_pos_o(pos_c[1]), .quo_neg_o(neg_c[1])
	);

	div_r4_stage u_stage1 (
		.sum_i(sum_c[1]), .carry_i(carry_c[1]), .divisor_i(divisor_q),
		.quo_pos_i(pos_c[1]), .quo_neg_i(neg_c[1]),
		.sum_o(sum_c[2]), .carry_o(carry_c[2]), .quo_pos_o(pos_c[2]), .quo_neg_o(neg_c[2])
	);

	div_r4_stage u_stage2 (
		.sum_i(sum_c[2]), .carry_i(carry_c[2]), .divisor_i(divisor_q),
		.quo_pos_i(pos_c[2]), .quo_neg_i(neg_c[2]),
		.sum_o(sum_c[3]), .carry_o(carry_c[3]), .quo_pos_o(pos_c[3]), .quo_neg_o(neg_c[3])
	);

	// load while idle, step while iterating, hold otherwise
	always_ff @(posedge clk) begin
		if (load_i) begin
			sum_q     <= rem_init_i;
			carry_q   <= '0;
			divisor_q <= divisor_i;
			pos_q     <= '0;
			neg_q     <= '0;
		end else if (iter_i) begin
			sum_q   <= sum_c[`STAGES_PER_CYCLE];
			carry_q <= carry_c[`STAGES_PER_CYCLE];
			pos_q   <= pos_c[`STAGES_PER_CYCLE];
			neg_q   <= neg_c[`STAGES_PER_CYCLE];
		end
	end

	assign rem.rem_sum   = sum_q;
	assign rem.rem_carry = carry_q;
	assign rem.divisor   = divisor_q;
	assign rem.quo_pos   = pos_q;
	assign rem.quo_neg   = neg_q;

endmodule

// ==== hw/srt_div_defs.svh ====
`ifndef SRT_DIV_DEFS_SVH
`define SRT_DIV_DEFS_SVH

// ==============================
// datapath widths
// ==============================
// significand in, one word
`define FRAC_W 53
// quotient out, 53 bits plus one guard bit
`define QUO_W 54
// carry-save remainder, 3 guard bits over the significand and 5 below
`define REM_W 61
// significand times a 5-bit scaling factor
`define SCALED_W 58
`define SCALE_W 5
// top remainder bits that feed digit selection
`define EST_W 6

// ==============================
// iteration
// ==============================
`define STAGES_PER_CYCLE 3
`define FP16_FRAC_W 11
`define FP32_FRAC_W 24
`define FP64_FRAC_W 53
// six quotient bits per cycle
`define ITER_FP16 2
`define ITER_FP32 4
`define ITER_FP64 9
`define ITER_CNT_W 4

`endif

// ==== hw/srt_div_pkg.sv ====
package srt_div_pkg;

	// ==============================
	// controller states
	// ==============================
	typedef enum logic [1:0] {
		DIV_IDLE = 2'd0,
		DIV_ITER = 2'd1,
		DIV_POST = 2'd2,
		DIV_DONE = 2'd3
	} div_state_e;

	// operand format, code 3 is not used
	typedef enum logic [1:0] {
		FMT_FP16 = 2'd0,
		FMT_FP32 = 2'd1,
		FMT_FP64 = 2'd2
	} fp_fmt_e;

	// one-hot radix-4 digit, -2 in the msb down to +2 in the lsb
	typedef enum logic [4:0] {
		DIG_NEG2 = 5'b10000,
		DIG_NEG1 = 5'b01000,
		DIG_ZERO = 5'b00100,
		DIG_POS1 = 5'b00010,
		DIG_POS2 = 5'b00001
	} quo_dig_e;

endpackage

// ==== hw/srt_frac_div.sv ====
`timescale 1ns/1ps
`include "srt_div_defs.svh"

module srt_frac_div
	import srt_div_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              start_valid_i,
	output logic              start_ready_o,
	input  logic              flush_i,
	input  fp_fmt_e           fp_format_i,
	input  logic [`FRAC_W-1:0] a_frac_i,
	input  logic [`FRAC_W-1:0] b_frac_i,
	output logic              finish_valid_o,
	input  logic              finish_ready_i,
	output logic [`QUO_W-1:0] fpdiv_frac_o
);

	// control levels
	logic load;
	logic iter;
	logic capture;

	// prescaler into the core
	logic [`REM_W-1:0]    rem_init;
	logic [`SCALED_W-1:0] divisor;

	// iteration state, core to post
	srt_rem_if u_rem_if ();

	// ==============================
	// control
	// ==============================
	div_ctrl u_ctrl (
		.clk            (clk),
		.rst_n          (rst_n),
		.start_valid_i  (start_valid_i),
		.flush_i        (flush_i),
		.finish_ready_i (finish_ready_i),
		.fp_format_i    (fp_format_i),
		.start_ready_o  (start_ready_o),
		.finish_valid_o (finish_valid_o),
		.load_o         (load),
		.iter_o         (iter),
		.capture_o      (capture)
	);

	// ==============================
	// datapath
	// ==============================
	div_prescale u_prescale (
		.fp_format_i (fp_format_i),
		.a_frac_i    (a_frac_i),
		.b_frac_i    (b_frac_i),
		.rem_init_o  (rem_init),
		.divisor_o   (divisor)
	);

	div_srt_core u_core (
		.clk        (clk),
		.load_i     (load),
		.iter_i     (iter),
		.rem_init_i (rem_init),
		.divisor_i  (divisor),
		.rem        (u_rem_if.core)
	);

	div_post u_post (
		.clk       (clk),
		.capture_i (capture),
		.rem       (u_rem_if.post),
		.quo_o     (fpdiv_frac_o)
	);

endmodule

// ==== hw/srt_rem_if.sv ====
`timescale 1ns/1ps
`include "srt_div_defs.svh"

// iteration state, from the SRT core to the post stage
interface srt_rem_if;

	// remainder in carry-save form
	logic [`REM_W-1:0]    rem_sum;
	logic [`REM_W-1:0]    rem_carry;
	// scaled divisor, held for the whole division
	logic [`SCALED_W-1:0] divisor;
	// redundant quotient, positive and negative digits apart
	logic [`QUO_W-1:0]    quo_pos;
	logic [`QUO_W-1:0]    quo_neg;

	// core side owns every register
	modport core (
		output rem_sum, rem_carry, divisor, quo_pos, quo_neg
	);

	// post stage only reads
	modport post (
		input rem_sum, rem_carry, divisor, quo_pos, quo_neg
	);

endinterface

// ==== sim/tb_srt_frac_div.sv ====
`timescale 1ns/1ps
`include "srt_div_defs.svh"

module tb_srt_frac_div
	import srt_div_pkg::*;
();

	localparam int WAIT_LIMIT = 100;

	logic                clk;
	logic                rst_n;
	logic                start_valid_i;
	logic                flush_i;
	logic                finish_ready_i;
	fp_fmt_e             fp_format_i;
	logic [`FRAC_W-1:0]  a_frac_i;
	logic [`FRAC_W-1:0]  b_frac_i;
	logic                start_ready_o;
	logic                finish_valid_o;
	logic [`QUO_W-1:0]   fpdiv_frac_o;

	logic [31:0] lfsr_q;
	int          err_cnt;
	int          check_cnt;
	int          test_cnt;
	int          test_fail;

	srt_frac_div DUT (
		.clk            (clk),
		.rst_n          (rst_n),
		.start_valid_i  (start_valid_i),
		.start_ready_o  (start_ready_o),
		.flush_i        (flush_i),
		.fp_format_i    (fp_format_i),
		.a_frac_i       (a_frac_i),
		.b_frac_i       (b_frac_i),
		.finish_valid_o (finish_valid_o),
		.finish_ready_i (finish_ready_i),
		.fpdiv_frac_o   (fpdiv_frac_o)
	);

	// 20 ns clock
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ==============================
	// random numbers and model
	// ==============================
	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one lfsr step per bit taken
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			r = {r[62:0], lfsr_q[0]};
		end
		return r;
	endfunction

	function automatic int frac_width(input fp_fmt_e fmt);
		case (fmt)
			FMT_FP16: return 11;
			FMT_FP32: return 24;
			default:  return 53;
		endcase
	endfunction

	// cycles in the iteration state, six quotient bits each
	function automatic int iter_count(input fp_fmt_e fmt);
		case (fmt)
			FMT_FP16: return 2;
			FMT_FP32: return 4;
			default:  return 9;
		endcase
	endfunction

	// normalized operand, leading bit of the format set, upper bits zero
	function automatic logic [63:0] rand_operand(input fp_fmt_e fmt);
		int          w;
		logic [63:0] v;
		w = frac_width(fmt);
		v = rand_bits(w);
		v[w-1] = 1'b1;
		return v;
	endfunction

	function automatic fp_fmt_e rand_format();
		logic [63:0] sel;
		sel = rand_bits(2);
		if (sel == 0)
			return FMT_FP16;
		else if (sel == 1)
			return FMT_FP32;
		else
			return FMT_FP64;
	endfunction

	// floor(x' * 2^(Q-1) / d), x' doubled when x < d
	function automatic logic [63:0] model_quo(input logic [63:0] x, input logic [63:0] d,
			input fp_fmt_e fmt);
		int           q;
		logic [127:0] xp;
		logic [127:0] quo;
		q   = 6 * iter_count(fmt);
		xp  = (x < d) ? {63'd0, x, 1'b0} : {64'd0, x};
		quo = (xp << (q - 1)) / {64'd0, d};
		return quo[63:0];
	endfunction

	// ==============================
	// checks and handshakes
	// ==============================
	task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string what);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("mismatch at %0t: %s, got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic fail_timeout(input string what);
		$display("timeout at %0t: %s, controller in %s", $time, what,
			DUT.u_ctrl.state_q.name());
		$display("Simulation finished: FAIL");
		$finish;
	endtask

	task automatic wait_ready();
		int cycles;
		cycles = 0;
		while (start_ready_o !== 1'b1 && cycles < WAIT_LIMIT) begin
			@(posedge clk);
			#2;
			cycles++;
		end
		if (start_ready_o !== 1'b1)
			fail_timeout("start_ready_o never came back high");
	endtask

	// returns 2 ns after the accept edge
	task automatic send_start(input fp_fmt_e fmt, input logic [63:0] a, input logic [63:0] b);
		wait_ready();
		fp_format_i   = fmt;
		a_frac_i      = a[`FRAC_W-1:0];
		b_frac_i      = b[`FRAC_W-1:0];
		start_valid_i = 1'b1;
		@(posedge clk);
		#2;
		start_valid_i = 1'b0;
	endtask

	task automatic collect(input fp_fmt_e fmt, input logic [63:0] a, input logic [63:0] b,
			input int hold);
		int          cycles;
		logic [63:0] got;
		string       tag;
		cycles = 0;
		tag    = $sformatf("%s a %0h b %0h", fmt.name(), a, b);
		while (finish_valid_o !== 1'b1 && cycles < WAIT_LIMIT) begin
			@(posedge clk);
			#2;
			cycles++;
		end
		if (finish_valid_o !== 1'b1)
			fail_timeout("finish_valid_o never rose after an accepted start");
		check_val(cycles, iter_count(fmt) + 1, {"latency ", tag});
		got = fpdiv_frac_o;
		check_val(got, model_quo(a, b, fmt), {"quotient ", tag});
		// result held while the consumer stalls
		for (int i = 0; i < hold; i++) begin
			@(posedge clk);
			#2;
			check_val(finish_valid_o, 1, "finish_valid_o under back-pressure");
			check_val(fpdiv_frac_o, got, "fpdiv_frac_o under back-pressure");
			check_val(start_ready_o, 0, "start_ready_o under back-pressure");
		end
		finish_ready_i = 1'b1;
		@(posedge clk);
		#2;
		finish_ready_i = 1'b0;
		check_val(finish_valid_o, 0, "finish_valid_o after the result is taken");
		check_val(start_ready_o, 1, "start_ready_o after the result is taken");
	endtask

	task automatic run_div(input fp_fmt_e fmt, input logic [63:0] a, input logic [63:0] b,
			input int hold);
		send_start(fmt, a, b);
		collect(fmt, a, b, hold);
	endtask

	task automatic report_test(input string name, input int errs_before);
		test_cnt++;
		if (err_cnt == errs_before) begin
			$display("test %0d %s: ok", test_cnt, name);
		end else begin
			test_fail++;
			$display("test %0d %s: failed with %0d mismatches", test_cnt, name,
				err_cnt - errs_before);
		end
	endtask

	// ==============================
	// test sequence
	// ==============================
	initial begin
		int          errs0;
		fp_fmt_e     fmt;
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] ones;
		logic [63:0] minv;
		lfsr_q         = 32'hb5c9;
		err_cnt        = 0;
		check_cnt      = 0;
		test_cnt       = 0;
		test_fail      = 0;
		rst_n          = 1'b0;
		start_valid_i  = 1'b0;
		flush_i        = 1'b0;
		finish_ready_i = 1'b0;
		fp_format_i    = FMT_FP64;
		a_frac_i       = '0;
		b_frac_i       = '0;
		repeat (5) @(posedge clk);
		#2;
		rst_n = 1'b1;

		errs0 = err_cnt;
		check_val(start_ready_o, 1, "start_ready_o after reset");
		check_val(finish_valid_o, 0, "finish_valid_o after reset");
		report_test("reset state", errs0);

		errs0 = err_cnt;
		for (int i = 0; i < 200; i++) begin
			a = rand_operand(FMT_FP64);
			b = rand_operand(FMT_FP64);
			run_div(FMT_FP64, a, b, 0);
		end
		report_test("random fp64", errs0);

		errs0 = err_cnt;
		for (int i = 0; i < 200; i++) begin
			fmt = rand_bits(1) ? FMT_FP32 : FMT_FP16;
			a   = rand_operand(fmt);
			b   = rand_operand(fmt);
			run_div(fmt, a, b, 0);
		end
		report_test("random fp32 and fp16", errs0);

		errs0 = err_cnt;
		for (int i = 0; i < 40; i++) begin
			fmt = rand_format();
			a   = rand_operand(fmt);
			b   = rand_operand(fmt);
			run_div(fmt, a, b, int'(rand_bits(3)));
		end
		report_test("back-pressure", errs0);

		// flush lands a few cycles into an fp64 iteration
		errs0 = err_cnt;
		for (int i = 0; i < 10; i++) begin
			send_start(FMT_FP64, rand_operand(FMT_FP64), rand_operand(FMT_FP64));
			repeat (3) @(posedge clk);
			#2;
			flush_i = 1'b1;
			@(posedge clk);
			#2;
			flush_i = 1'b0;
			check_val(start_ready_o, 1, "start_ready_o after flush");
			check_val(finish_valid_o, 0, "finish_valid_o after flush");
			fmt = rand_format();
			a   = rand_operand(fmt);
			b   = rand_operand(fmt);
			run_div(fmt, a, b, 0);
		end
		report_test("flush", errs0);

		errs0 = err_cnt;
		for (int k = 0; k < 3; k++) begin
			fmt  = (k == 0) ? FMT_FP16 : ((k == 1) ? FMT_FP32 : FMT_FP64);
			ones = (64'd1 << frac_width(fmt)) - 64'd1;
			minv = 64'd1 << (frac_width(fmt) - 1);
			a    = rand_operand(fmt);
			run_div(fmt, a, a, 0);
			run_div(fmt, ones, ones, 0);
			run_div(fmt, ones, minv, 0);
			run_div(fmt, minv, ones, 0);
		end
		report_test("edge operands", errs0);

		$display("tests %0d, tests failed %0d, checks %0d, mismatches %0d",
			test_cnt, test_fail, check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule
